// ==== sprite_core_defines.svh ====
`ifndef SPRITE_CORE_DEFINES_SVH
`define SPRITE_CORE_DEFINES_SVH

// Datapath and instruction widths
`define SC_XLEN        32
`define SC_ILEN        36

// Storage sizes
`define SC_NUM_REGS    32
`define SC_NUM_SPRITES 64
`define SC_NUM_FIELDS  8
`define SC_PROG_DEPTH  64  // Also the halt address

// Canvas of 320 x 240 with 8 animation frames
`define SC_X_W         9
`define SC_Y_W         8
`define SC_FRAME_W     3

`endif

// ==== sprite_core_pkg.sv ====
`include "sprite_core_defines.svh"

package sprite_core_pkg;

  typedef enum logic [7:0] {
    OP_NOP   = 8'h00,
    OP_LI    = 8'h01,
    OP_ADDI  = 8'h02,
    OP_SUBI  = 8'h03,
    OP_ADD   = 8'h04,
    OP_SUB   = 8'h05,  // Saturates at zero
    OP_SPLI  = 8'h10,
    OP_SPADD = 8'h11,
    OP_LISP  = 8'h12,
    OP_BEQ   = 8'h20,
    OP_BNE   = 8'h21,
    OP_JMP   = 8'h22
  } opcode_e;

  typedef struct packed {
    logic                               pad;
    logic [11:0]                        imm;  // Branch target for BEQ, BNE, JMP
    logic [$clog2(`SC_NUM_REGS)-1:0]    rs2;
    logic [$clog2(`SC_NUM_REGS)-1:0]    rs1;
    logic [$clog2(`SC_NUM_REGS)-1:0]    rd;
    opcode_e                            opcode;
  } reg_fmt_t;

  typedef struct packed {
    logic [1:0]                         pad;
    logic [11:0]                        imm;
    logic [$clog2(`SC_NUM_REGS)-1:0]    rs1;  // Destination for LISP
    logic [$clog2(`SC_NUM_FIELDS)-1:0]  field;
    logic [$clog2(`SC_NUM_SPRITES)-1:0] sprite_id;
    opcode_e                            opcode;
  } spr_fmt_t;

  typedef union packed {
    reg_fmt_t r;
    spr_fmt_t s;
  } instr_u;

  typedef struct packed {
    logic                               we;
    logic [$clog2(`SC_PROG_DEPTH)-1:0]  addr;
    logic [`SC_ILEN-1:0]                data;
  } prog_wr_t;

  typedef struct packed {
    logic                               valid;
    logic                               to_sprite;
    logic [$clog2(`SC_NUM_REGS)-1:0]    rd;
    logic [$clog2(`SC_NUM_SPRITES)-1:0] sprite_id;
    logic [$clog2(`SC_NUM_FIELDS)-1:0]  field;
    logic [`SC_XLEN-1:0]                data;
  } ex_result_t;

  typedef struct packed {
    logic                               taken;
    logic [$clog2(`SC_PROG_DEPTH)-1:0]  target;
  } redirect_t;

  typedef struct packed {
    logic                               valid;
    logic [`SC_X_W-1:0]                 x;
    logic [`SC_Y_W-1:0]                 y;
    logic [`SC_FRAME_W-1:0]             frame;
  } sprite_out_t;

endpackage

// ==== instr_mem.sv ====
`include "sprite_core_defines.svh"

module instr_mem
  import sprite_core_pkg::*;
(
  input  logic                              pixel_clk_in,
  input  prog_wr_t                          prog_wr,
  input  logic [$clog2(`SC_PROG_DEPTH)-1:0] fetch_pc,
  output logic [`SC_ILEN-1:0]               instr_word
);

  logic [`SC_ILEN-1:0] mem [`SC_PROG_DEPTH];

  // Load port, used while the core is held in reset
  always_ff @(posedge pixel_clk_in) begin
    if (prog_wr.we) begin
      mem[prog_wr.addr] <= prog_wr.data;
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    instr_word <= mem[fetch_pc];  // Word valid one edge after the PC
  end

endmodule

// ==== fetch_unit.sv ====
`include "sprite_core_defines.svh"

module fetch_unit
  import sprite_core_pkg::*;
(
  input  logic                              pixel_clk_in,
  input  logic                              rst_in,
  input  redirect_t                         redirect,
  input  logic                              ex_valid,
  output logic [$clog2(`SC_PROG_DEPTH)-1:0] fetch_pc,
  output logic                              ifetch_valid,
  output logic                              halted
);

  logic [$clog2(`SC_PROG_DEPTH):0] pc;  // Extra bit to reach the halt address
  logic                            pc_done;
  logic                            drained;

  assign pc_done  = (pc == `SC_PROG_DEPTH);
  assign drained  = pc_done && !ifetch_valid && !ex_valid;
  assign fetch_pc = pc[$clog2(`SC_PROG_DEPTH)-1:0];

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      pc           <= '0;
      ifetch_valid <= 1'b0;
      halted       <= 1'b0;
    end else begin
      if (redirect.taken) begin
        pc <= {1'b0, redirect.target};
      end else if (!pc_done) begin
        pc <= pc + 1'b1;
      end
      ifetch_valid <= !pc_done && !redirect.taken;  // Squash the fetch behind a taken branch
      if (drained) begin
        halted <= 1'b1;  // Sticky until reset
      end
    end
  end

endmodule

// ==== reg_file.sv ====
`include "sprite_core_defines.svh"

module reg_file
  import sprite_core_pkg::*;
(
  input  logic                            pixel_clk_in,
  input  logic [$clog2(`SC_NUM_REGS)-1:0] rs1_addr,
  input  logic [$clog2(`SC_NUM_REGS)-1:0] rs2_addr,
  output logic [`SC_XLEN-1:0]             rs1_data,
  output logic [`SC_XLEN-1:0]             rs2_data,
  input  ex_result_t                      wr
);

  logic [`SC_XLEN-1:0] regs [`SC_NUM_REGS];

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  always_ff @(posedge pixel_clk_in) begin
    if (wr.valid && !wr.to_sprite) begin
      regs[wr.rd] <= wr.data;
    end
  end

endmodule

// ==== sprite_table.sv ====
`include "sprite_core_defines.svh"

module sprite_table
  import sprite_core_pkg::*;
(
  input  logic                               pixel_clk_in,
  input  logic                               rst_in,
  input  logic [$clog2(`SC_NUM_SPRITES)-1:0] rd_id,
  input  logic [$clog2(`SC_NUM_FIELDS)-1:0]  rd_field,
  output logic [`SC_XLEN-1:0]                rd_data,
  input  logic [$clog2(`SC_NUM_SPRITES)-1:0] scan_id,
  output logic [3:0][`SC_XLEN-1:0]           scan_fields,
  input  ex_result_t                         wr
);

  logic [`SC_XLEN-1:0] fields [`SC_NUM_SPRITES][`SC_NUM_FIELDS];

  assign rd_data = fields[rd_id][rd_field];

  // Active flag, x, y and frame of the sprite being scanned
  always_comb begin
    for (int f = 0; f < 4; f++) begin
      scan_fields[f] = fields[scan_id][f];
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < `SC_NUM_SPRITES; i++) begin
        fields[i][0] <= '0;  // All sprites inactive
      end
    end else if (wr.valid && wr.to_sprite) begin
      fields[wr.sprite_id][wr.field] <= wr.data;
    end
  end

endmodule

// ==== execute_stage.sv ====
`include "sprite_core_defines.svh"

module execute_stage
  import sprite_core_pkg::*;
(
  input  logic                               pixel_clk_in,
  input  logic                               rst_in,
  input  logic [`SC_ILEN-1:0]                instr_word,
  input  logic                               ifetch_valid,
  output logic [$clog2(`SC_NUM_REGS)-1:0]    rs1_addr,
  output logic [$clog2(`SC_NUM_REGS)-1:0]    rs2_addr,
  input  logic [`SC_XLEN-1:0]                rs1_data,
  input  logic [`SC_XLEN-1:0]                rs2_data,
  output logic [$clog2(`SC_NUM_SPRITES)-1:0] sp_id,
  output logic [$clog2(`SC_NUM_FIELDS)-1:0]  sp_field,
  input  logic [`SC_XLEN-1:0]                sp_data,
  output redirect_t                          redirect,
  output ex_result_t                         ex_res
);

  instr_u              ins;
  opcode_e             op;
  logic                spr_form;
  logic [`SC_XLEN-1:0] src_a;
  logic [`SC_XLEN-1:0] src_b;
  logic [`SC_XLEN-1:0] src_sp;
  logic [`SC_XLEN-1:0] imm_r;
  logic [`SC_XLEN-1:0] imm_s;
  logic                take;
  ex_result_t          res_d;
  ex_result_t          res_q;
  logic                res_valid;

  assign ins      = instr_u'(instr_word);
  assign op       = ins.r.opcode;
  assign spr_form = (op == OP_SPLI) || (op == OP_SPADD) || (op == OP_LISP);

  assign rs1_addr = spr_form ? ins.s.rs1 : ins.r.rs1;
  assign rs2_addr = ins.r.rs2;
  assign sp_id    = ins.s.sprite_id;
  assign sp_field = ins.s.field;

  assign imm_r = `SC_XLEN'(ins.r.imm);
  assign imm_s = `SC_XLEN'(ins.s.imm);

  // Bypass from the result that commits at the coming edge
  assign src_a = (ex_res.valid && !ex_res.to_sprite && ex_res.rd == rs1_addr) ?
                 ex_res.data : rs1_data;
  assign src_b = (ex_res.valid && !ex_res.to_sprite && ex_res.rd == rs2_addr) ?
                 ex_res.data : rs2_data;
  assign src_sp = (ex_res.valid && ex_res.to_sprite && ex_res.sprite_id == sp_id &&
                   ex_res.field == sp_field) ? ex_res.data : sp_data;

  always_comb begin
    res_d           = '0;
    res_d.rd        = ins.r.rd;
    res_d.sprite_id = ins.s.sprite_id;
    res_d.field     = ins.s.field;
    take            = 1'b0;
    case (op)
      OP_LI: begin
        res_d.valid = 1'b1;
        res_d.data  = imm_r;
      end
      OP_ADDI: begin
        res_d.valid = 1'b1;
        res_d.data  = src_a + imm_r;
      end
      OP_SUBI: begin
        res_d.valid = 1'b1;
        res_d.data  = src_a - imm_r;  // Wraps
      end
      OP_ADD: begin
        res_d.valid = 1'b1;
        res_d.data  = src_a + src_b;
      end
      OP_SUB: begin
        res_d.valid = 1'b1;
        res_d.data  = (src_a < src_b) ? '0 : src_a - src_b;
      end
      OP_SPLI: begin
        res_d.valid     = 1'b1;
        res_d.to_sprite = 1'b1;
        res_d.data      = imm_s;
      end
      OP_SPADD: begin
        res_d.valid     = 1'b1;
        res_d.to_sprite = 1'b1;
        res_d.data      = src_sp + src_a;
      end
      OP_LISP: begin
        res_d.valid = 1'b1;
        res_d.rd    = ins.s.rs1;
        res_d.data  = src_sp;
      end
      OP_BEQ: take = (src_a == src_b);
      OP_BNE: take = (src_a != src_b);
      OP_JMP: take = 1'b1;
      default: take = 1'b0;  // NOP and unknown codes
    endcase
  end

  assign redirect.taken  = ifetch_valid && take;
  assign redirect.target = ins.r.imm[$clog2(`SC_PROG_DEPTH)-1:0];

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= ifetch_valid && res_d.valid;  // Squashed words never commit
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    res_q <= res_d;
  end

  assign ex_res = '{
    valid:     res_valid,
    to_sprite: res_q.to_sprite,
    rd:        res_q.rd,
    sprite_id: res_q.sprite_id,
    field:     res_q.field,
    data:      res_q.data
  };

endmodule

// ==== sprite_scanner.sv ====
`include "sprite_core_defines.svh"

module sprite_scanner
  import sprite_core_pkg::*;
(
  input  logic                               pixel_clk_in,
  input  logic                               rst_in,
  input  logic                               new_frame,
  output logic [$clog2(`SC_NUM_SPRITES)-1:0] scan_id,
  input  logic [3:0][`SC_XLEN-1:0]           scan_fields,
  output sprite_out_t                        sprite_out
);

  logic [$clog2(`SC_NUM_SPRITES):0] idx;  // MSB set when idle
  logic                             scanning;
  logic                             hit;
  logic                             out_valid;
  logic [`SC_X_W-1:0]               x_q;
  logic [`SC_Y_W-1:0]               y_q;
  logic [`SC_FRAME_W-1:0]           frame_q;

  assign scanning = !idx[$clog2(`SC_NUM_SPRITES)];
  assign scan_id  = idx[$clog2(`SC_NUM_SPRITES)-1:0];
  assign hit      = scanning && (scan_fields[0] != '0);

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      idx       <= {1'b1, {$clog2(`SC_NUM_SPRITES){1'b0}}};
      out_valid <= 1'b0;
    end else begin
      if (new_frame) begin
        idx <= '0;  // Restart even mid-scan
      end else if (scanning) begin
        idx <= idx + 1'b1;
      end
      out_valid <= hit;
    end
  end

  // Position holds its last value for inactive sprites
  always_ff @(posedge pixel_clk_in) begin
    if (hit) begin
      x_q     <= scan_fields[1][`SC_X_W-1:0];
      y_q     <= scan_fields[2][`SC_Y_W-1:0];
      frame_q <= scan_fields[3][`SC_FRAME_W-1:0];
    end
  end

  assign sprite_out = '{valid: out_valid, x: x_q, y: y_q, frame: frame_q};

endmodule

// ==== sprite_core_top.sv ====
`include "sprite_core_defines.svh"

module sprite_core_top
  import sprite_core_pkg::*;
(
  input  logic        pixel_clk_in,
  input  logic        rst_in,
  input  prog_wr_t    prog_wr,
  input  logic        new_frame,
  output sprite_out_t sprite_out,
  output logic        halted
);

  logic [$clog2(`SC_PROG_DEPTH)-1:0]  fetch_pc;
  logic                               ifetch_valid;
  logic [`SC_ILEN-1:0]                instr_word;
  redirect_t                          redirect;
  ex_result_t                         ex_res;
  logic [$clog2(`SC_NUM_REGS)-1:0]    rs1_addr;
  logic [$clog2(`SC_NUM_REGS)-1:0]    rs2_addr;
  logic [`SC_XLEN-1:0]                rs1_data;
  logic [`SC_XLEN-1:0]                rs2_data;
  logic [$clog2(`SC_NUM_SPRITES)-1:0] sp_id;
  logic [$clog2(`SC_NUM_FIELDS)-1:0]  sp_field;
  logic [`SC_XLEN-1:0]                sp_data;
  logic [$clog2(`SC_NUM_SPRITES)-1:0] scan_id;
  logic [3:0][`SC_XLEN-1:0]           scan_fields;

  instr_mem i_instr_mem (
    .pixel_clk_in (pixel_clk_in),
    .prog_wr      (prog_wr),
    .fetch_pc     (fetch_pc),
    .instr_word   (instr_word)
  );

  fetch_unit i_fetch_unit (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .redirect     (redirect),
    .ex_valid     (ex_res.valid),
    .fetch_pc     (fetch_pc),
    .ifetch_valid (ifetch_valid),
    .halted       (halted)
  );

  execute_stage i_execute_stage (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .instr_word   (instr_word),
    .ifetch_valid (ifetch_valid),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .sp_id        (sp_id),
    .sp_field     (sp_field),
    .sp_data      (sp_data),
    .redirect     (redirect),
    .ex_res       (ex_res)
  );

  reg_file i_reg_file (
    .pixel_clk_in (pixel_clk_in),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .wr           (ex_res)
  );

  sprite_table i_sprite_table (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .rd_id        (sp_id),
    .rd_field     (sp_field),
    .rd_data      (sp_data),
    .scan_id      (scan_id),
    .scan_fields  (scan_fields),
    .wr           (ex_res)
  );

  sprite_scanner i_sprite_scanner (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .new_frame    (new_frame),
    .scan_id      (scan_id),
    .scan_fields  (scan_fields),
    .sprite_out   (sprite_out)
  );

endmodule

// ==== sprite_core_sva.sv ====
module sprite_core_sva
  import sprite_core_pkg::*;
(
  input logic        pixel_clk_in,
  input logic        rst_in,
  input logic        new_frame,
  input sprite_out_t sprite_out,
  input logic        halted
);

  logic [6:0] since_frame;  // Saturates at 127

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      since_frame <= 7'd127;
    end else if (new_frame) begin
      since_frame <= '0;
    end else if (since_frame != 7'd127) begin
      since_frame <= since_frame + 7'd1;
    end
  end

  halted_sticky: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    halted |=> halted) else $error("halted fell without a reset");

  valid_low_after_reset: assert property (@(posedge pixel_clk_in)
    rst_in |=> !sprite_out.valid) else $error("sprite_out.valid high after reset");

  valid_needs_frame: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    sprite_out.valid |-> since_frame <= 7'd65)
    else $error("sprite_out.valid high with no recent new_frame");

endmodule

bind sprite_core_top sprite_core_sva i_sva (
  .pixel_clk_in (pixel_clk_in),
  .rst_in       (rst_in),
  .new_frame    (new_frame),
  .sprite_out   (sprite_out),
  .halted       (halted)
);

// ==== tb_sprite_core.sv ====
`include "sprite_core_defines.svh"

module tb_sprite_core
  import sprite_core_pkg::*;
();

  localparam int NUM_TESTS   = 6;
  localparam int CYCLE_LIMIT = NUM_TESTS * (3 * `SC_PROG_DEPTH + 160);

  // Program word in decoded form for the reference model
  typedef struct packed {
    opcode_e     op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [5:0]  id;
    logic [2:0]  fld;
    logic [11:0] imm;
  } op_rec_t;

  logic        pixel_clk_in;
  logic        rst_in;
  prog_wr_t    prog_wr;
  logic        new_frame;
  sprite_out_t sprite_out;
  logic        halted;

  logic [31:0]         rng_state;
  int                  cycles = 0;
  int                  errors;
  int                  test_errors;
  int                  tests_run;
  int                  prog_len;
  op_rec_t             prog [`SC_PROG_DEPTH];
  logic [`SC_XLEN-1:0] m_regs [`SC_NUM_REGS];
  logic [`SC_XLEN-1:0] m_spr [`SC_NUM_SPRITES][`SC_NUM_FIELDS];

  sprite_core_top i_dut (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .prog_wr      (prog_wr),
    .new_frame    (new_frame),
    .sprite_out   (sprite_out),
    .halted       (halted)
  );

  initial begin
    pixel_clk_in = 1'b0;
    forever #2 pixel_clk_in = ~pixel_clk_in;
  end

  always @(posedge pixel_clk_in) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [11:0] rand12();
    logic [31:0] r;
    r = next_rand();
    return r[11:0];
  endfunction

  // Sprite form for sprite opcodes, register form otherwise
  function automatic logic [`SC_ILEN-1:0] encode(input op_rec_t r);
    if (r.op == OP_SPLI || r.op == OP_SPADD || r.op == OP_LISP) begin
      return {2'b00, r.imm, r.rs1, r.fld, r.id, r.op};
    end else begin
      return {1'b0, r.imm, r.rs2, r.rs1, r.rd, r.op};
    end
  endfunction

  task automatic clear_prog();
    for (int a = 0; a < `SC_PROG_DEPTH; a++) begin
      prog[a] = '0;
    end
    prog_len = 0;
  endtask

  task automatic emit(input opcode_e op, input int rd, input int rs1, input int rs2,
                      input int id, input int fld, input logic [11:0] imm);
    prog[prog_len] = '{op: op, rd: 5'(rd), rs1: 5'(rs1), rs2: 5'(rs2),
                       id: 6'(id), fld: 3'(fld), imm: imm};
    prog_len++;
  endtask

  // Fields 0 to 3 of one sprite
  task automatic spli4(input int id, input logic zero_ok);
    logic [11:0] v;
    for (int f = 0; f < 4; f++) begin
      v = rand12();
      if (f == 0) begin
        v = (zero_ok && v[11:10] == 2'b00) ? 12'd0 : (v | 12'd1);  // Nonzero unless zero_ok
      end
      emit(OP_SPLI, 0, 0, 0, id, f, v);
    end
  endtask

  task automatic run_model();
    int      pc;
    op_rec_t r;
    logic    take;
    pc = 0;
    while (pc < `SC_PROG_DEPTH) begin
      r    = prog[pc];
      take = 1'b0;
      case (r.op)
        OP_LI:    m_regs[r.rd] = {20'd0, r.imm};
        OP_ADDI:  m_regs[r.rd] = m_regs[r.rs1] + {20'd0, r.imm};
        OP_SUBI:  m_regs[r.rd] = m_regs[r.rs1] - {20'd0, r.imm};
        OP_ADD:   m_regs[r.rd] = m_regs[r.rs1] + m_regs[r.rs2];
        OP_SUB:   m_regs[r.rd] = (m_regs[r.rs1] < m_regs[r.rs2]) ?
                                 32'd0 : m_regs[r.rs1] - m_regs[r.rs2];
        OP_SPLI:  m_spr[r.id][r.fld] = {20'd0, r.imm};
        OP_SPADD: m_spr[r.id][r.fld] = m_spr[r.id][r.fld] + m_regs[r.rs1];
        OP_LISP:  m_regs[r.rs1] = m_spr[r.id][r.fld];
        OP_BEQ:   take = (m_regs[r.rs1] == m_regs[r.rs2]);
        OP_BNE:   take = (m_regs[r.rs1] != m_regs[r.rs2]);
        OP_JMP:   take = 1'b1;
        default:  take = 1'b0;
      endcase
      pc = take ? int'(r.imm) : pc + 1;
    end
  endtask

  function automatic sprite_out_t expect_sprite(input int i);
    sprite_out_t e;
    e.valid = (m_spr[i][0] != '0);
    e.x     = m_spr[i][1][`SC_X_W-1:0];
    e.y     = m_spr[i][2][`SC_Y_W-1:0];
    e.frame = m_spr[i][3][`SC_FRAME_W-1:0];
    return e;
  endfunction

  task automatic check_sprite(input int idx, input sprite_out_t got, input sprite_out_t exp,
                              input logic check_pos);
    logic bad;
    bad = (got.valid !== exp.valid);
    if (check_pos && {got.x, got.y, got.frame} !== {exp.x, exp.y, exp.frame}) begin
      bad = 1'b1;
    end
    if (bad) begin
      $display("FAILED %0t: sprite %0d got v%0b x%0d y%0d f%0d, expected v%0b x%0d y%0d f%0d",
               $time, idx, got.valid, got.x, got.y, got.frame,
               exp.valid, exp.x, exp.y, exp.frame);
      test_errors++;
    end
  endtask

  task automatic check_halted(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAILED %0t: halted is %0b %s, expected %0b", $time, got, what, exp);
      test_errors++;
    end
  endtask

  // Load while reset is held, then run until the core halts
  task automatic load_and_run();
    for (int a = 0; a < `SC_PROG_DEPTH; a++) begin
      @(negedge pixel_clk_in);
      rst_in  = 1'b1;
      prog_wr = '{we: 1'b1, addr: 6'(a), data: encode(prog[a])};
    end
    @(negedge pixel_clk_in);
    prog_wr.we = 1'b0;
    repeat (2) @(negedge pixel_clk_in);
    rst_in = 1'b0;
    for (int i = 0; i < `SC_NUM_SPRITES; i++) begin
      m_spr[i][0] = '0;
    end
    run_model();
    check_halted(halted, 1'b0, "after reset");
    while (halted !== 1'b1) begin
      @(negedge pixel_clk_in);
    end
  endtask

  // Inactive sprites keep the position of the last active one
  task automatic run_scan(input int stop);
    sprite_out_t want;
    sprite_out_t held;
    logic        held_known;
    held_known = 1'b0;
    held       = '0;
    @(negedge pixel_clk_in);
    new_frame = 1'b1;
    @(negedge pixel_clk_in);
    new_frame = 1'b0;
    for (int i = 0; i < stop; i++) begin
      @(negedge pixel_clk_in);
      want = expect_sprite(i);
      if (want.valid) begin
        held       = want;
        held_known = 1'b1;
      end else begin
        want.x     = held.x;
        want.y     = held.y;
        want.frame = held.frame;
      end
      check_sprite(i, sprite_out, want, held_known);
    end
    if (stop == `SC_NUM_SPRITES) begin
      @(negedge pixel_clk_in);
      want       = held;
      want.valid = 1'b0;
      check_sprite(stop, sprite_out, want, held_known);  // Walk finished
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %0d (%s): ok", tests_run, name);
    end else begin
      $display("Test %0d (%s): %0d mismatches", tests_run, name, test_errors);
    end
    errors      += test_errors;
    test_errors  = 0;
  endtask

  task automatic test_reg_arith();
    int base;
    clear_prog();
    for (int k = 0; k < 3; k++) begin
      base = int'(next_rand() % 26);
      emit(OP_LI,   base,     0,        0,        0, 0, rand12());
      emit(OP_ADDI, base + 1, base,     0,        0, 0, rand12());
      emit(OP_SUBI, base + 2, base + 1, 0,        0, 0, rand12());
      emit(OP_ADD,  base + 3, base + 2, base,     0, 0, 12'd0);
      emit(OP_SUB,  base + 4, base + 3, base + 1, 0, 0, 12'd0);
      emit(OP_SUB,  base + 5, base,     base + 1, 0, 0, 12'd0);  // Saturates at zero
      for (int e = 0; e < 2; e++) begin
        spli4(int'(next_rand() % 64), 1'b0);
        emit(OP_SPADD, 0, base + 4 + e, 0, prog[prog_len - 1].id, 1, 12'd0);
      end
    end
    load_and_run();
    run_scan(`SC_NUM_SPRITES);
    finish_test("register arithmetic");
  endtask

  task automatic test_round_trip();
    int id;
    int r;
    int gap;
    clear_prog();
    for (int j = 0; j < 4; j++) begin
      id  = int'(next_rand() % 64);
      r   = int'(next_rand() % 32);
      gap = (j % 2) * 2;  // Zero gap uses the bypass
      spli4(id, 1'b0);
      repeat (gap) emit(OP_NOP, 0, 0, 0, 0, 0, 12'd0);
      emit(OP_LISP, 0, r, 0, id, 3, 12'd0);
      repeat (gap) emit(OP_NOP, 0, 0, 0, 0, 0, 12'd0);
      emit(OP_ADDI, r, r, 0, 0, 0, rand12());
      repeat (gap) emit(OP_NOP, 0, 0, 0, 0, 0, 12'd0);
      emit(OP_SPADD, 0, r, 0, id, 3, 12'd0);
    end
    load_and_run();
    run_scan(`SC_NUM_SPRITES);
    finish_test("sprite round trip");
  endtask

  task automatic test_branches();
    logic [31:0] r;
    logic [11:0] v;
    opcode_e     br_op;
    int          ra;
    clear_prog();
    for (int b = 0; b < 6; b++) begin
      r  = next_rand();
      ra = int'(next_rand() % 31);
      spli4(int'(r[5:0]), 1'b0);
      v = rand12();
      emit(OP_LI, ra, 0, 0, 0, 0, v);
      emit(OP_LI, ra + 1, 0, 0, 0, 0, r[31] ? v : rand12());
      case (b % 3)
        0:       br_op = OP_BEQ;
        1:       br_op = OP_BNE;
        default: br_op = OP_JMP;
      endcase
      emit(br_op, 0, ra, ra + 1, 0, 0, 12'(prog_len + 3));
      emit(OP_SPLI, 0, 0, 0, int'(r[5:0]), 1, rand12());  // Skipped when taken
      emit(OP_SPLI, 0, 0, 0, int'(r[5:0]), 2, rand12());
    end
    load_and_run();
    run_scan(`SC_NUM_SPRITES);
    finish_test("branches");
  endtask

  initial begin
    rng_state   = 32'h8503;
    rst_in      = 1'b1;
    new_frame   = 1'b0;
    prog_wr     = '0;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    repeat (2) @(negedge pixel_clk_in);

    clear_prog();
    load_and_run();
    run_scan(`SC_NUM_SPRITES);
    check_halted(halted, 1'b1, "after scan");
    finish_test("empty program");

    clear_prog();
    for (int k = 0; k < 12; k++) begin
      spli4(int'(next_rand() % 64), 1'b1);
    end
    load_and_run();
    run_scan(`SC_NUM_SPRITES);
    finish_test("sprite immediates");

    test_reg_arith();
    test_round_trip();
    test_branches();

    clear_prog();
    for (int k = 0; k < 12; k++) begin
      spli4(int'(next_rand() % 64), 1'b1);
    end
    load_and_run();
    run_scan(5 + int'(next_rand() % 40));
    run_scan(`SC_NUM_SPRITES);  // Timing counted from the second pulse
    finish_test("scan restart");

    $display("Tests run: %0d, mismatches: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
sprite_core_pkg.sv
instr_mem.sv
fetch_unit.sv
reg_file.sv
sprite_table.sv
execute_stage.sv
sprite_scanner.sv
sprite_core_top.sv
sprite_core_sva.sv
tb_sprite_core.sv

// ==== Bender.yml ====
package:
  name: sprite_core

sources:
  - include_dirs:
      - .
    files:
      - sprite_core_pkg.sv
      - instr_mem.sv
      - fetch_unit.sv
      - reg_file.sv
      - sprite_table.sv
      - execute_stage.sv
      - sprite_scanner.sv
      - sprite_core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - sprite_core_sva.sv
      - tb_sprite_core.sv
